/* test/alignCases.txt */
// op funct3 address data, all hex
// op 1 store, 2 load; funct3 bit 2 unsigned
// fill 0x100 to 0x13f with known doubles
1 3 0100 8796a5b4c3d2e1f0
1 3 0108 0f1e2d3c4b5a6978
1 3 0110 f0e1d2c3b4a59687
1 3 0118 7f80817e7d828384
1 3 0120 1122334455667788
1 3 0128 99aabbccddeeff00
1 3 0130 0123456789abcdef
1 3 0138 fedcba9876543210
// aligned loads, every size, signed and unsigned
2 0 0100 0
2 4 0100 0
2 1 0106 0
2 5 0106 0
2 2 0104 0
2 6 0104 0
2 3 0108 0
2 0 0119 0
// misaligned loads, most crossing a word boundary
2 1 0107 0
2 5 010f 0
2 2 0115 0
2 6 011d 0
2 3 0103 0
2 3 011b 0
2 2 0111 0
// misaligned stores, neighbors read back
1 2 0126 a1b2c3d4
2 3 0120 0
2 3 0128 0
1 1 012f 5566
2 3 0130 0
1 3 0134 a5a5a5a5c3c3c3c3
2 3 0130 0
2 3 0138 0
// load right after a store to the same word
1 0 0102 5a
2 3 0100 0
1 1 0109 beef
2 3 0108 0

/* filelist.f */
hdl/lsuAlignPkg.sv
hdl/byteMaskGen.sv
hdl/accessStageReg.sv
hdl/spillAlign.sv
hdl/dataRam.sv
hdl/loadFormat.sv
hdl/lsuAlignTop.sv
test/alignChecker.sv
test/tbLsuAlign.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the load/store alignment testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tbLsuAlign -f filelist.f -o simLsuAlign
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/simLsuAlign > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qF '*** FAILED ***' sim.log; then
  exit 1
fi
exit 0

/* test/tbLsuAlign.sv */
////////////////////
// testbench for the load/store alignment path
// replays the cases file into the DUT and checker
////////////////////

`timescale 1ns/1ps

module tbLsuAlign;

  localparam int LLEN      = 64;
  localparam int RAM_WORDS = 256;
  localparam int MAX_CASES = 64;

  logic                          clk;
  logic                          arstN;
  lsuAlignPkg::memCtl_t          ctlE;
  logic [lsuAlignPkg::ADR_W-1:0] adrE;
  logic [LLEN-1:0]               wrDataE;
  logic                          spillStall, loadValid;
  logic [LLEN-1:0]               loadData;
  logic                          endOfTest, finalDone;
  int                            valueErrs, protoErrs, pending;

  logic [LLEN-1:0] caseMem [4*MAX_CASES];  // op, funct3, address, data per case
  int              caseCount;
  int              cycles;
  int              timeoutLimit;
  bit              running;

  lsuAlignTop #(.LLEN(LLEN), .RAM_WORDS(RAM_WORDS)) i_dut (
    .clk, .arstN, .ctlE, .adrE, .wrDataE, .spillStall, .loadValid, .loadData
  );

  alignChecker #(.LLEN(LLEN), .RAM_WORDS(RAM_WORDS)) i_check (
    .clk, .arstN, .ctlE, .adrE, .wrDataE, .spillStall, .loadValid, .loadData,
    .endOfTest, .valueErrs, .protoErrs, .pending, .finalDone
  );

  always #50 clk = ~clk;  // 100 ns period

  // watchdog limit comes from the case count
  always @(posedge clk) begin
    if (running) cycles++;
    if (running && cycles > timeoutLimit) begin
      $display("timeout: run still busy after %0d cycles", timeoutLimit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // drive one case and hold it until the DUT takes it
  task automatic issueRequest(input int idx);
    logic stallNow;
    ctlE.rw     = lsuAlignPkg::memRw_t'(caseMem[4*idx][1:0]);
    ctlE.funct3 = caseMem[4*idx+1][2:0];
    adrE        = caseMem[4*idx+2][lsuAlignPkg::ADR_W-1:0];
    wrDataE     = caseMem[4*idx+3];
    stallNow    = 1'b1;
    while (stallNow) begin
      stallNow = spillStall;  // stable between edges
      @(negedge clk);
    end
  endtask

  task automatic idleCycles(input int n);
    ctlE = '0;
    repeat (n) @(negedge clk);
  endtask

  // true when case idx is a store and the next case loads the same word
  function automatic bit loadFollowsStore(input int idx);
    logic [lsuAlignPkg::ADR_W-1:0] stAdr;
    logic [lsuAlignPkg::ADR_W-1:0] ldAdr;
    stAdr = caseMem[4*idx+2][lsuAlignPkg::ADR_W-1:0];
    ldAdr = caseMem[4*idx+6][lsuAlignPkg::ADR_W-1:0];
    return (caseMem[4*idx][1:0] == 2'b01) && (caseMem[4*idx+4][1:0] == 2'b10) &&
           ((stAdr >> $clog2(LLEN/8)) == (ldAdr >> $clog2(LLEN/8)));
  endfunction

  initial begin
    clk       = 1'b0;
    arstN     = 1'b0;
    ctlE      = '0;
    adrE      = '0;
    wrDataE   = '0;
    endOfTest = 1'b0;
    running   = 1'b0;
    cycles    = 0;
    caseCount = 0;
    void'($urandom(32'h49e4));
    for (int i = 0; i < 4*MAX_CASES; i++) caseMem[i] = '1;  // all ones marks the end
    $readmemh("test/alignCases.txt", caseMem);
    while (caseCount < MAX_CASES && caseMem[4*caseCount] != '1) caseCount++;
    timeoutLimit = caseCount * 4 + 20;

    repeat (3) @(posedge clk);
    @(negedge clk);
    arstN   = 1'b1;
    running = 1'b1;

    for (int i = 0; i < caseCount; i++) begin
      issueRequest(i);
      // a load of the word just stored follows at once and reads through the RAM bypass
      if (i + 1 == caseCount || !loadFollowsStore(i)) begin
        idleCycles($urandom % 3);  // gap of 0 to 2 cycles
      end
    end
    idleCycles(3);
    while (pending != 0) @(negedge clk);
    endOfTest = 1'b1;
    while (!finalDone) @(negedge clk);

    $display("%0d cases, %0d value errors, %0d protocol errors", caseCount, valueErrs,
             protoErrs);
    if (valueErrs == 0 && protoErrs == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* test/alignChecker.sv */
////////////////////
// load/store checker
// byte model of the RAM and in-order load compare
////////////////////

`timescale 1ns/1ps

module alignChecker #(
  parameter int LLEN      = 64,
  parameter int RAM_WORDS = 256
) (
  input  logic                          clk,
  input  logic                          arstN,
  input  lsuAlignPkg::memCtl_t          ctlE,
  input  logic [lsuAlignPkg::ADR_W-1:0] adrE,
  input  logic [LLEN-1:0]               wrDataE,
  input  logic                          spillStall,
  input  logic                          loadValid,
  input  logic [LLEN-1:0]               loadData,
  input  logic                          endOfTest,   // stimulus done, run the count checks
  output int                            valueErrs,
  output int                            protoErrs,
  output int                            pending,     // loads still waiting for a result
  output logic                          finalDone
);

  localparam int BYTES = LLEN/8;

  logic [7:0]      model [RAM_WORDS*BYTES];  // one entry per RAM byte
  logic [LLEN-1:0] expQ [$];                 // expected results, oldest first
  logic [LLEN-1:0] expWord;
  logic            stallPrev;
  int              accSize;
  int              loadsTaken, validSeen, stallExp, stallSeen;

  // little-endian read of the access bytes, extended unless funct3[2]
  function automatic logic [LLEN-1:0] expectLoad(input logic [2:0] f3, input int adr);
    int              n;
    logic [LLEN-1:0] val;
    n   = 1 << f3[1:0];
    val = '0;
    for (int b = 0; b < n; b++) val[8*b +: 8] = model[adr + b];
    if (!f3[2] && val[8*n-1]) begin
      for (int b = n; b < BYTES; b++) val[8*b +: 8] = 8'hff;  // sign fill
    end
    return val;
  endfunction

  always @(posedge clk) begin
    if (!arstN) begin
      valueErrs = 0;
      protoErrs = 0;
      pending   = 0;
      finalDone = 1'b0;
      stallPrev = 1'b0;
      loadsTaken = 0;
      validSeen  = 0;
      stallExp   = 0;
      stallSeen  = 0;
    end else begin
      ////////////////////
      // results leave before new requests enter
      if (loadValid) begin
        validSeen++;
        if (expQ.size() == 0) begin
          protoErrs++;
          $display("loadValid at time %0t with no load outstanding", $time);
        end else begin
          expWord = expQ.pop_front();
          if (loadData !== expWord) begin
            valueErrs++;
            $display("FAILED %0t: load result expected %h, got %h", $time, expWord, loadData);
          end
        end
      end

      // one stall cycle per spill, never two in a row
      if (spillStall) begin
        stallSeen++;
        if (stallPrev) begin
          protoErrs++;
          $display("spillStall stayed high for more than one cycle at time %0t", $time);
        end
      end
      stallPrev = spillStall;

      ////////////////////
      // accepted request, stores go straight into the model
      if (ctlE.rw != lsuAlignPkg::RW_IDLE && !spillStall) begin
        accSize = 1 << ctlE.funct3[1:0];
        if ((int'(adrE) & (accSize - 1)) != 0) stallExp++;  // size-misaligned spills
        if (ctlE.rw[0]) begin
          for (int b = 0; b < accSize; b++) model[int'(adrE) + b] = wrDataE[8*b +: 8];
        end else begin
          expQ.push_back(expectLoad(ctlE.funct3, int'(adrE)));
          loadsTaken++;
        end
      end
      pending = expQ.size();

      if (endOfTest && !finalDone) begin
        if (validSeen != loadsTaken) begin
          valueErrs++;
          $display("FAILED %0t: %0d loadValid cycles for %0d loads", $time, validSeen,
                   loadsTaken);
        end
        if (stallSeen != stallExp) begin
          valueErrs++;
          $display("FAILED %0t: %0d stall cycles, expected %0d", $time, stallSeen, stallExp);
        end
        finalDone = 1'b1;
      end
    end
  end

endmodule

/* hdl/lsuAlignTop.sv */
////////////////////
// load/store alignment top
// stage register, mask, spill unit, RAM, formatter
////////////////////

`timescale 1ns/1ps

module lsuAlignTop #(
  parameter int LLEN      = 64,
  parameter int RAM_WORDS = 256
) (
  input  logic                          clk,
  input  logic                          arstN,
  input  lsuAlignPkg::memCtl_t          ctlE,
  input  logic [lsuAlignPkg::ADR_W-1:0] adrE,
  input  logic [LLEN-1:0]               wrDataE,
  output logic                          spillStall,
  output logic                          loadValid,
  output logic [LLEN-1:0]               loadData
);

  lsuAlignPkg::memCtl_t          ctlM;
  logic [lsuAlignPkg::ADR_W-1:0] adrM;
  logic [LLEN-1:0]               wrDataM;
  logic [LLEN/8-1:0]             byteMask, byteMaskExt;
  logic [lsuAlignPkg::ADR_W-1:0] adrSpillE, adrSpillM;
  logic [LLEN-1:0]               wrWord;
  logic [LLEN/8-1:0]             wrMask;
  logic                          wrEn;
  logic [LLEN-1:0]               rdWordM;
  logic [LLEN-1:0]               alignedData;

  accessStageReg #(.LLEN(LLEN)) i_stageReg (
    .clk, .arstN, .spillStall, .ctlE, .adrE, .wrDataE, .ctlM, .adrM, .wrDataM
  );

  byteMaskGen #(.LLEN(LLEN)) i_maskGen (
    .ctlM, .adrM, .byteMask, .byteMaskExt
  );

  spillAlign #(.LLEN(LLEN)) i_spill (
    .clk, .arstN, .ctlM, .adrE, .adrM, .rdWordM, .wrDataM, .byteMask, .byteMaskExt,
    .adrSpillE, .adrSpillM, .wrWord, .wrMask, .wrEn, .alignedData, .spillStall,
    .loadValid
  );

  // reads in E, writes in M
  dataRam #(.LLEN(LLEN), .RAM_WORDS(RAM_WORDS)) i_ram (
    .clk, .wrEn, .wrAdr(adrSpillM), .wrWord, .wrMask, .rdAdr(adrSpillE), .rdWord(rdWordM)
  );

  loadFormat #(.LLEN(LLEN)) i_format (
    .ctlM, .alignedData, .loadData
  );

endmodule

/* hdl/loadFormat.sv */
////////////////////
// load formatter
// sign or zero extension by access size
////////////////////

`timescale 1ns/1ps

module loadFormat #(
  parameter int LLEN = 64
) (
  input  lsuAlignPkg::memCtl_t ctlM,
  input  logic [LLEN-1:0]      alignedData,
  output logic [LLEN-1:0]      loadData
);

  logic [LLEN-1:0] lowMask;  // bytes kept from the aligned data
  logic            signBit;  // top bit of the selected field

  always_comb begin
    case (lsuAlignPkg::memSize_t'(ctlM.funct3[1:0]))
      lsuAlignPkg::SIZE_B: begin
        lowMask = LLEN'(8'hff);
        signBit = alignedData[7];
      end
      lsuAlignPkg::SIZE_H: begin
        lowMask = LLEN'(16'hffff);
        signBit = alignedData[15];
      end
      lsuAlignPkg::SIZE_W: begin
        lowMask = LLEN'(32'hffff_ffff);
        signBit = alignedData[31];
      end
      default: begin  // double fills the word
        lowMask = '1;
        signBit = alignedData[LLEN-1];
      end
    endcase
  end

  // funct3[2] picks zero extension
  assign loadData = (alignedData & lowMask) | ({LLEN{signBit & ~ctlM.funct3[2]}} & ~lowMask);

endmodule

/* hdl/dataRam.sv */
////////////////////
// data RAM
// word array, byte enables, registered read
// same-edge write is forwarded to the read
////////////////////

`timescale 1ns/1ps

module dataRam #(
  parameter int LLEN      = 64,
  parameter int RAM_WORDS = 256
) (
  input  logic                          clk,
  input  logic                          wrEn,
  input  logic [lsuAlignPkg::ADR_W-1:0] wrAdr,   // byte address, word aligned
  input  logic [LLEN-1:0]               wrWord,
  input  logic [LLEN/8-1:0]             wrMask,
  input  logic [lsuAlignPkg::ADR_W-1:0] rdAdr,   // byte address, word aligned
  output logic [LLEN-1:0]               rdWord
);

  localparam int BYTES = LLEN/8;
  localparam int OFFW  = $clog2(BYTES);
  localparam int IDXW  = $clog2(RAM_WORDS);

  logic [LLEN-1:0] mem [RAM_WORDS];
  logic [IDXW-1:0] wrIdx, rdIdx;
  logic [LLEN-1:0] rdMerged;  // stored word with this edge's writes applied

  assign wrIdx = wrAdr[OFFW +: IDXW];
  assign rdIdx = rdAdr[OFFW +: IDXW];

  // write-first on a collision
  always_comb begin
    rdMerged = mem[rdIdx];
    for (int b = 0; b < BYTES; b++) begin
      if (wrEn && wrMask[b] && (wrIdx == rdIdx)) rdMerged[8*b +: 8] = wrWord[8*b +: 8];
    end
  end

  always_ff @(posedge clk) begin
    for (int b = 0; b < BYTES; b++) begin
      if (wrEn && wrMask[b]) mem[wrIdx][8*b +: 8] <= wrWord[8*b +: 8];
    end
    rdWord <= rdMerged;
  end

  a_wrInRange: assert property (
    @(posedge clk) wrEn |-> (wrAdr >> OFFW) < lsuAlignPkg::ADR_W'(RAM_WORDS)
  );

endmodule

/* hdl/spillAlign.sv */
////////////////////
// spill unit
// splits word-crossing accesses in two, merges loads
// and rotates store data across both words
////////////////////

`timescale 1ns/1ps

module spillAlign #(
  parameter int LLEN = 64
) (
  input  logic                          clk,
  input  logic                          arstN,
  input  lsuAlignPkg::memCtl_t          ctlM,
  input  logic [lsuAlignPkg::ADR_W-1:0] adrE,
  input  logic [lsuAlignPkg::ADR_W-1:0] adrM,
  input  logic [LLEN-1:0]               rdWordM,
  input  logic [LLEN-1:0]               wrDataM,
  input  logic [LLEN/8-1:0]             byteMask,
  input  logic [LLEN/8-1:0]             byteMaskExt,
  output logic [lsuAlignPkg::ADR_W-1:0] adrSpillE,   // RAM read address
  output logic [lsuAlignPkg::ADR_W-1:0] adrSpillM,   // RAM write address
  output logic [LLEN-1:0]               wrWord,
  output logic [LLEN/8-1:0]             wrMask,
  output logic                          wrEn,
  output logic [LLEN-1:0]               alignedData, // load data moved down to byte 0
  output logic                          spillStall,
  output logic                          loadValid
);

  localparam int BYTES = LLEN/8;
  localparam int OFFW  = $clog2(BYTES);
  localparam int ADR_W = lsuAlignPkg::ADR_W;

  typedef enum logic {READY, SPILL} spillState_t;

  spillState_t       state, stateNext;
  logic [OFFW-1:0]   byteOff;      // offset inside the word
  logic [OFFW-1:0]   sizeMask;     // offset bits that must be zero for this size
  logic              misaligned;
  logic              inSpill;
  logic [OFFW+2:0]   shiftAmt;     // bit shift, 8 per byte
  logic [ADR_W-1:0]  adrInc;       // next word of the access
  logic [LLEN-1:0]   firstWord;
  logic [2*LLEN-1:0] rdPair;
  logic [2*LLEN-1:0] rdShifted;
  logic [3*LLEN-1:0] wrShiftedExt;
  logic [2*LLEN-1:0] wrPair;

  function automatic logic [ADR_W-1:0] wordBase(input logic [ADR_W-1:0] adr);
    return {adr[ADR_W-1:OFFW], {OFFW{1'b0}}};  // round down to the word
  endfunction

  ////////////////////
  // spill detection

  assign byteOff = adrM[OFFW-1:0];

  always_comb begin
    case (lsuAlignPkg::memSize_t'(ctlM.funct3[1:0]))
      lsuAlignPkg::SIZE_B: sizeMask = '0;
      lsuAlignPkg::SIZE_H: sizeMask = OFFW'(3'd1);
      lsuAlignPkg::SIZE_W: sizeMask = OFFW'(3'd3);
      default:             sizeMask = OFFW'(3'd7);
    endcase
  end

  // no cache line, so every misaligned access takes the second word
  assign misaligned = (ctlM.rw != lsuAlignPkg::RW_IDLE) && ((byteOff & sizeMask) != '0);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) state <= READY;
    else        state <= stateNext;
  end

  always_comb begin
    case (state)
      READY:   stateNext = misaligned ? SPILL : READY;
      default: stateNext = READY;  // second half takes one cycle
    endcase
  end

  assign inSpill    = (state == SPILL);
  assign spillStall = (state == READY) && misaligned;
  assign loadValid  = ctlM.rw[1] && (inSpill || !misaligned);

  ////////////////////
  // address muxes

  assign adrInc    = adrM + ADR_W'(BYTES);
  assign adrSpillE = spillStall ? wordBase(adrInc) : wordBase(adrE);  // fetch second word early
  assign adrSpillM = inSpill ? wordBase(adrInc) : wordBase(adrM);

  ////////////////////
  // load merge

  // first word sits on rdWordM during the stall cycle
  always_ff @(posedge clk) begin
    if (spillStall) firstWord <= rdWordM;
  end

  assign shiftAmt    = {byteOff, 3'b000};
  assign rdPair      = inSpill ? {rdWordM, firstWord} : {rdWordM, rdWordM};
  assign rdShifted   = rdPair >> shiftAmt;
  assign alignedData = rdShifted[LLEN-1:0];

  ////////////////////
  // store split

  // triple copy so no zeros are shifted into live lanes
  assign wrShiftedExt = {wrDataM, wrDataM, wrDataM} << shiftAmt;
  assign wrPair       = wrShiftedExt[3*LLEN-1:LLEN];
  assign wrWord       = inSpill ? wrPair[2*LLEN-1:LLEN] : wrPair[LLEN-1:0];
  assign wrMask       = inSpill ? byteMaskExt : byteMask;
  assign wrEn         = ctlM.rw[0] && (wrMask != '0);  // empty half writes nothing

  ////////////////////
  // checks

  // the second half runs on the control that stalled
  a_spillSameCtl: assert property (
    @(posedge clk) disable iff (!arstN) inSpill |-> $stable(ctlM)
  );

  // the stalled request stays put in M for its second half
  a_stallHoldsReq: assert property (
    @(posedge clk) disable iff (!arstN)
    spillStall |-> (ctlM.rw != lsuAlignPkg::RW_IDLE) ##1 (inSpill && $stable(adrM))
  );

endmodule

/* hdl/accessStageReg.sv */
////////////////////
// E to M stage register
// holds the request while a spill stalls the pipe
////////////////////

`timescale 1ns/1ps

module accessStageReg #(
  parameter int LLEN = 64
) (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic                          spillStall,
  input  lsuAlignPkg::memCtl_t          ctlE,
  input  logic [lsuAlignPkg::ADR_W-1:0] adrE,
  input  logic [LLEN-1:0]               wrDataE,
  output lsuAlignPkg::memCtl_t          ctlM,
  output logic [lsuAlignPkg::ADR_W-1:0] adrM,
  output logic [LLEN-1:0]               wrDataM
);

  // control goes idle on reset so nothing fires in M
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ctlM.rw     <= lsuAlignPkg::RW_IDLE;
      ctlM.funct3 <= '0;
    end else if (!spillStall) begin
      ctlM <= ctlE;  // idle E gives idle M
    end
  end

  // payload, only meaningful alongside ctlM
  always_ff @(posedge clk) begin
    if (!spillStall) begin
      adrM    <= adrE;
      wrDataM <= wrDataE;
    end
  end

endmodule

/* hdl/byteMaskGen.sv */
////////////////////
// byte mask generator
// two-word byte mask from size and offset
////////////////////

`timescale 1ns/1ps

module byteMaskGen #(
  parameter int LLEN = 64
) (
  input  lsuAlignPkg::memCtl_t          ctlM,
  input  logic [lsuAlignPkg::ADR_W-1:0] adrM,
  output logic [LLEN/8-1:0]             byteMask,    // bytes in the addressed word
  output logic [LLEN/8-1:0]             byteMaskExt  // bytes spilling into the next word
);

  localparam int BYTES = LLEN/8;
  localparam int OFFW  = $clog2(BYTES);

  logic [2*BYTES-1:0] sizeRun;  // ones for each byte of the access
  logic [2*BYTES-1:0] maskPair;

  always_comb begin
    case (lsuAlignPkg::memSize_t'(ctlM.funct3[1:0]))
      lsuAlignPkg::SIZE_B: sizeRun = (2*BYTES)'(8'h01);
      lsuAlignPkg::SIZE_H: sizeRun = (2*BYTES)'(8'h03);
      lsuAlignPkg::SIZE_W: sizeRun = (2*BYTES)'(8'h0f);
      default:             sizeRun = (2*BYTES)'(8'hff);  // double
    endcase
  end

  // place the run at the byte offset, overflow lands in the upper half
  assign maskPair    = (ctlM.rw == lsuAlignPkg::RW_IDLE) ? '0 : sizeRun << adrM[OFFW-1:0];
  assign byteMask    = maskPair[BYTES-1:0];
  assign byteMaskExt = maskPair[2*BYTES-1:BYTES];

endmodule

/* hdl/lsuAlignPkg.sv */
////////////////////
// load/store alignment shared types
// request control, access size and address width
////////////////////

package lsuAlignPkg;

  // byte address width for every block in the LSU path
  parameter int ADR_W = 16;

  // read/write code, bit 1 read, bit 0 write
  typedef logic [1:0] memRw_t;

  localparam memRw_t RW_IDLE = 2'b00;  // no request in this stage

  // low bits of funct3 give the access size
  typedef enum logic [1:0] {
    SIZE_B,  // byte
    SIZE_H,  // half
    SIZE_W,  // word
    SIZE_D   // double, only with a 64-bit data path
  } memSize_t;

  // request control carried from E into M
  typedef struct packed {
    memRw_t     rw;
    logic [2:0] funct3;  // bit 2 set means unsigned load
  } memCtl_t;

endpackage
